// File: design/mduCluster_config.svh
`ifndef MDU_CLUSTER_CONFIG_SVH
`define MDU_CLUSTER_CONFIG_SVH

// Number of independent lanes, 1 to 8
`define MDU_LANES 4

// Cycles from start to result, busy is high for exactly this long
`define MDU_MULT_CYCLES 5
`define MDU_DIV_CYCLES 10

// Host address layout
// Lane index sits above the stride, register index in bits 4 to 2
`define MDU_ADDR_WIDTH 8
`define MDU_LANE_STRIDE 32

`endif

// File: design/mduPkg.sv
package mduPkg;

	// Data word of the host bus and of HI, LO
	typedef logic [31:0] mduWordT;

	// Operation codes written to CTRL, codes 6 and 7 do nothing
	typedef enum logic [2:0]
	{
		MULT  = 3'd0,
		MULTU = 3'd1,
		DIV   = 3'd2,
		DIVU  = 3'd3,
		MTLO  = 3'd4,
		MTHI  = 3'd5
	} mduOpT;

	// Register index within a lane, byte offset divided by four
	typedef enum logic [2:0]
	{
		SRCA   = 3'd0,
		SRCB   = 3'd1,
		CTRL   = 3'd2,
		HI     = 3'd3,
		LO     = 3'd4,
		STATUS = 3'd5
	} mduRegT;

endpackage

// File: design/mduCmdIf.sv
`timescale 1ns/100ps

interface mduCmdIf;
	import mduPkg::*;

	// Start is a one-cycle pulse, op and operands are valid with it
	logic start;
	mduOpT op;
	mduWordT srcA;
	mduWordT srcB;

	modport issuer
	(
		output start,
		output op,
		output srcA,
		output srcB
	);

	modport lane
	(
		input start,
		input op,
		input srcA,
		input srcB
	);

endinterface

// File: design/mduRegWrite.sv
`timescale 1ns/100ps
`include "mduCluster_config.svh"

module mduRegWrite
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       awvalid,
	output logic                       awready,
	input  logic [`MDU_ADDR_WIDTH-1:0] awaddr,
	input  logic                       wvalid,
	output logic                       wready,
	input  mduPkg::mduWordT            wdata,
	output logic                       bvalid,
	input  logic                       bready,
	output logic [1:0]                 bresp,
	mduCmdIf.issuer                    cmd [`MDU_LANES]
);
	import mduPkg::*;

	localparam int LaneLsb = $clog2(`MDU_LANE_STRIDE);
	localparam int LaneW = `MDU_ADDR_WIDTH - LaneLsb;

	logic acceptQ;
	logic writeFire;
	logic [LaneW-1:0] writeLane;
	mduRegT writeReg;
	mduOpT pendingOp;

	// Address and data channels are taken together
	assign awready = acceptQ;
	assign wready = acceptQ;
	assign bresp = 2'b00;

	assign writeFire = acceptQ && awvalid && wvalid;
	assign writeLane = awaddr[`MDU_ADDR_WIDTH-1:LaneLsb];
	assign writeReg = mduRegT'(awaddr[LaneLsb-1:2]);

	// One-cycle accept pulse, held off while a response is pending
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acceptQ <= 1'b0;
			bvalid <= 1'b0;
		end
		else
		begin
			acceptQ <= awvalid && wvalid && !bvalid && !acceptQ;
			if (writeFire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	// Only one command can be issued at a time, so the op is shared
	always_ff @(posedge clk)
	begin
		if (writeFire && writeReg == CTRL)
			pendingOp <= mduOpT'(wdata[2:0]);
	end

	////////////////////////////////////////////////////////////////////////////
	// Per-lane operands and start pulse
	////////////////////////////////////////////////////////////////////////////
	for (genvar i = 0; i < `MDU_LANES; i++)
	begin : gLane
		logic laneHit;
		logic startQ;
		mduWordT srcAQ;
		mduWordT srcBQ;

		// Lanes above the configured count never match
		assign laneHit = writeFire && (writeLane == LaneW'(i));

		always_ff @(posedge clk)
		begin
			if (laneHit && writeReg == SRCA)
				srcAQ <= wdata;
			if (laneHit && writeReg == SRCB)
				srcBQ <= wdata;
		end

		always_ff @(posedge clk)
		begin
			if (reset)
				startQ <= 1'b0;
			else
				startQ <= laneHit && writeReg == CTRL;
		end

		assign cmd[i].start = startQ;
		assign cmd[i].op = pendingOp;
		assign cmd[i].srcA = srcAQ;
		assign cmd[i].srcB = srcBQ;
	end

endmodule

// File: design/mduLane.sv
`timescale 1ns/100ps
`include "mduCluster_config.svh"

module mduLane
(
	input  logic            clk,
	input  logic            reset,
	mduCmdIf.lane           cmd,
	output mduPkg::mduWordT hi,
	output mduPkg::mduWordT lo,
	output logic            busy
);
	import mduPkg::*;

	localparam int MaxCycles = (`MDU_MULT_CYCLES > `MDU_DIV_CYCLES) ?
		`MDU_MULT_CYCLES : `MDU_DIV_CYCLES;
	localparam int CountW = $clog2(MaxCycles + 1);

	logic [CountW-1:0] count;
	logic launch;
	mduOpT opQ;
	mduWordT srcAQ;
	mduWordT srcBQ;
	logic [63:0] prodSigned;
	logic [63:0] prodUnsigned;
	mduWordT quotient;
	mduWordT remainder;
	mduWordT resHi;
	mduWordT resLo;

	assign busy = (count != '0);

	// A start that arrives while busy is dropped
	assign launch = cmd.start && !busy;

	////////////////////////////////////////////////////////////////////////////
	// Result datapath
	////////////////////////////////////////////////////////////////////////////

	// Low 64 bits of the product of sign-extended operands is the signed product
	assign prodSigned = {{32{srcAQ[31]}}, srcAQ} * {{32{srcBQ[31]}}, srcBQ};
	assign prodUnsigned = {32'd0, srcAQ} * {32'd0, srcBQ};

	always_comb
	begin
		// Zero divisor: quotient all ones, remainder is the dividend
		quotient = '1;
		remainder = srcAQ;
		if (srcBQ != '0)
		begin
			if (opQ == DIV)
			begin
				// Most negative over minus one overflows
				if (srcAQ == 32'h8000_0000 && srcBQ == '1)
				begin
					quotient = srcAQ;
					remainder = '0;
				end
				else
				begin
					quotient = $signed(srcAQ) / $signed(srcBQ);
					remainder = $signed(srcAQ) % $signed(srcBQ);
				end
			end
			else
			begin
				quotient = srcAQ / srcBQ;
				remainder = srcAQ % srcBQ;
			end
		end
	end

	always_comb
	begin
		case (opQ)
			MULT:
				{resHi, resLo} = prodSigned;
			MULTU:
				{resHi, resLo} = prodUnsigned;
			DIV, DIVU:
			begin
				resHi = remainder;
				resLo = quotient;
			end
			default:
			begin
				resHi = hi;
				resLo = lo;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Command capture and latency counter
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (launch)
		begin
			opQ <= cmd.op;
			srcAQ <= cmd.srcA;
			srcBQ <= cmd.srcB;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= '0;
			hi <= '0;
			lo <= '0;
		end
		else if (launch)
		begin
			case (cmd.op)
				MULT, MULTU:
					count <= CountW'(`MDU_MULT_CYCLES);
				DIV, DIVU:
					count <= CountW'(`MDU_DIV_CYCLES);
				MTLO:
					lo <= cmd.srcA;
				MTHI:
					hi <= cmd.srcA;
				default:
					count <= '0;
			endcase
		end
		else if (count != '0)
		begin
			count <= count - CountW'(1);
			// HI and LO land on the same edge that busy falls
			if (count == CountW'(1))
			begin
				hi <= resHi;
				lo <= resLo;
			end
		end
	end

endmodule

// File: design/mduRegRead.sv
`timescale 1ns/100ps
`include "mduCluster_config.svh"

module mduRegRead
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       arvalid,
	output logic                       arready,
	input  logic [`MDU_ADDR_WIDTH-1:0] araddr,
	output logic                       rvalid,
	input  logic                       rready,
	output mduPkg::mduWordT            rdata,
	output logic [1:0]                 rresp,
	input  mduPkg::mduWordT            laneHi [`MDU_LANES],
	input  mduPkg::mduWordT            laneLo [`MDU_LANES],
	input  logic                       laneBusy [`MDU_LANES]
);
	import mduPkg::*;

	localparam int LaneLsb = $clog2(`MDU_LANE_STRIDE);
	localparam int LaneW = `MDU_ADDR_WIDTH - LaneLsb;

	logic readFire;
	logic [LaneW-1:0] readLane;
	mduRegT readReg;
	mduWordT readValue;

	assign readFire = arready && arvalid;
	assign rresp = 2'b00;

	// Address is sampled on the handshake cycle
	assign readLane = araddr[`MDU_ADDR_WIDTH-1:LaneLsb];
	assign readReg = mduRegT'(araddr[LaneLsb-1:2]);

	always_comb
	begin
		readValue = '0;
		// Unmapped lanes match no index and fall through as zero
		for (int i = 0; i < `MDU_LANES; i++)
		begin
			if (readLane == LaneW'(i))
			begin
				case (readReg)
					HI:
						readValue = laneHi[i];
					LO:
						readValue = laneLo[i];
					STATUS:
						readValue = {31'd0, laneBusy[i]};
					default:
						readValue = '0;
				endcase
			end
		end
	end

	// Single outstanding read, next address waits for rvalid to drop
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			arready <= arvalid && !rvalid && !arready;
			if (readFire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// Held stable until the host takes it
	always_ff @(posedge clk)
	begin
		if (readFire)
			rdata <= readValue;
	end

endmodule

// File: design/mduCluster.sv
`timescale 1ns/100ps
`include "mduCluster_config.svh"

module mduCluster
(
	input  logic                       clk,
	input  logic                       reset,

	// AXI4-Lite write side
	input  logic                       awvalid,
	output logic                       awready,
	input  logic [`MDU_ADDR_WIDTH-1:0] awaddr,
	input  logic                       wvalid,
	output logic                       wready,
	input  mduPkg::mduWordT            wdata,
	output logic                       bvalid,
	input  logic                       bready,
	output logic [1:0]                 bresp,

	// AXI4-Lite read side
	input  logic                       arvalid,
	output logic                       arready,
	input  logic [`MDU_ADDR_WIDTH-1:0] araddr,
	output logic                       rvalid,
	input  logic                       rready,
	output mduPkg::mduWordT            rdata,
	output logic [1:0]                 rresp
);
	import mduPkg::*;

	mduWordT laneHi [`MDU_LANES];
	mduWordT laneLo [`MDU_LANES];
	logic laneBusy [`MDU_LANES];

	// One command bus per lane
	mduCmdIf cmdBus [`MDU_LANES] ();

	mduRegWrite uRegWrite
	(
		.clk     (clk),
		.reset   (reset),
		.awvalid (awvalid),
		.awready (awready),
		.awaddr  (awaddr),
		.wvalid  (wvalid),
		.wready  (wready),
		.wdata   (wdata),
		.bvalid  (bvalid),
		.bready  (bready),
		.bresp   (bresp),
		.cmd     (cmdBus)
	);

	for (genvar i = 0; i < `MDU_LANES; i++)
	begin : gLane
		mduLane uLane
		(
			.clk   (clk),
			.reset (reset),
			.cmd   (cmdBus[i]),
			.hi    (laneHi[i]),
			.lo    (laneLo[i]),
			.busy  (laneBusy[i])
		);
	end

	mduRegRead uRegRead
	(
		.clk      (clk),
		.reset    (reset),
		.arvalid  (arvalid),
		.arready  (arready),
		.araddr   (araddr),
		.rvalid   (rvalid),
		.rready   (rready),
		.rdata    (rdata),
		.rresp    (rresp),
		.laneHi   (laneHi),
		.laneLo   (laneLo),
		.laneBusy (laneBusy)
	);

endmodule

// File: bench/mduClusterTb.sv
`timescale 1ns/100ps
`include "mduCluster_config.svh"

module mduClusterTb;
	import mduPkg::*;

	localparam int WaitLimit = 64;
	localparam int PollLimit = 40;
	localparam int RandomOps = 200;
	localparam int OffSrcA = 'h00;
	localparam int OffSrcB = 'h04;
	localparam int OffCtrl = 'h08;
	localparam int OffHi = 'h0C;
	localparam int OffLo = 'h10;
	localparam int OffStatus = 'h14;

	logic clk;
	logic reset;
	logic awvalid;
	logic awready;
	logic [`MDU_ADDR_WIDTH-1:0] awaddr;
	logic wvalid;
	logic wready;
	logic [31:0] wdata;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	logic arvalid;
	logic arready;
	logic [`MDU_ADDR_WIDTH-1:0] araddr;
	logic rvalid;
	logic rready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic [31:0] lfsrState;
	int failCount;

	mduCluster u_dut
	(
		.clk     (clk),
		.reset   (reset),
		.awvalid (awvalid),
		.awready (awready),
		.awaddr  (awaddr),
		.wvalid  (wvalid),
		.wready  (wready),
		.wdata   (wdata),
		.bvalid  (bvalid),
		.bready  (bready),
		.bresp   (bresp),
		.arvalid (arvalid),
		.arready (arready),
		.araddr  (araddr),
		.rvalid  (rvalid),
		.rready  (rready),
		.rdata   (rdata),
		.rresp   (rresp)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	task automatic stopRun();
		$display("SOME TESTS FAILED");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			failCount++;
			$display("Error at %0t: %s expected %08h, got %08h", $time, name, expected, actual);
			stopRun();
		end
	endtask

	task automatic waitTimeout(input int waitCount, input string what);
		if (waitCount > WaitLimit)
		begin
			$display("Timeout while waiting for %s", what);
			stopRun();
		end
	endtask

	function automatic logic [7:0] laneAddr(input int lane, input int offset);
		return 8'(lane * `MDU_LANE_STRIDE + offset);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// AXI4-Lite transfers, hold delays the response handshake
	////////////////////////////////////////////////////////////////////////////
	task automatic writeWord(input logic [7:0] addr, input logic [31:0] data, input int hold);
		int waitCount;
		int i;
		@(posedge clk);
		awvalid <= 1'b1;
		awaddr <= addr;
		wvalid <= 1'b1;
		wdata <= data;
		waitCount = 0;
		do
		begin
			@(posedge clk);
			waitCount++;
			waitTimeout(waitCount, "awready and wready");
		end
		while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		waitCount = 0;
		while (!bvalid)
		begin
			@(posedge clk);
			waitCount++;
			waitTimeout(waitCount, "bvalid");
		end
		for (i = 0; i < hold; i++)
		begin
			@(posedge clk);
			checkValue("bvalid held", 32'd1, 32'(bvalid));
		end
		bready <= 1'b1;
		@(posedge clk);
		bready <= 1'b0;
		checkValue("bresp", 32'd0, 32'(bresp));
	endtask

	task automatic readWord(input logic [7:0] addr, output logic [31:0] data, input int hold);
		int waitCount;
		int i;
		@(posedge clk);
		arvalid <= 1'b1;
		araddr <= addr;
		waitCount = 0;
		do
		begin
			@(posedge clk);
			waitCount++;
			waitTimeout(waitCount, "arready");
		end
		while (!arready);
		arvalid <= 1'b0;
		// Address is free once the read is taken
		araddr <= '0;
		waitCount = 0;
		while (!rvalid)
		begin
			@(posedge clk);
			waitCount++;
			waitTimeout(waitCount, "rvalid");
		end
		data = rdata;
		// rdata must not move while rready is low
		for (i = 0; i < hold; i++)
		begin
			@(posedge clk);
			checkValue("rvalid held", 32'd1, 32'(rvalid));
			checkValue("rdata held", data, rdata);
		end
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
		checkValue("rresp", 32'd0, 32'(rresp));
	endtask

	task automatic startOp(input int lane, input logic [2:0] code, input logic [31:0] srcA,
		input logic [31:0] srcB);
		writeWord(laneAddr(lane, OffSrcA), srcA, 0);
		writeWord(laneAddr(lane, OffSrcB), srcB, 0);
		writeWord(laneAddr(lane, OffCtrl), {29'd0, code}, 0);
	endtask

	task automatic pollIdle(input int lane);
		logic [31:0] status;
		int polls;
		polls = 0;
		status = 32'd1;
		while (status[0])
		begin
			polls++;
			if (polls > PollLimit)
			begin
				$display("Timeout because lane %0d stayed busy", lane);
				stopRun();
			end
			readWord(laneAddr(lane, OffStatus), status, 0);
		end
	endtask

	task automatic checkLaneRegs(input int lane, input logic [31:0] expHi,
		input logic [31:0] expLo);
		logic [31:0] value;
		readWord(laneAddr(lane, OffHi), value, 0);
		checkValue($sformatf("lane %0d HI", lane), expHi, value);
		readWord(laneAddr(lane, OffLo), value, 0);
		checkValue($sformatf("lane %0d LO", lane), expLo, value);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Random operands and reference model
	////////////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic randomBits(input int width, output logic [31:0] value);
		int i;
		value = '0;
		for (i = 0; i < width; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
	endtask

	// Returns {HI, LO}
	function automatic logic [63:0] modelResult(input mduOpT op, input logic [31:0] a,
		input logic [31:0] b);
		longint sa;
		longint sb;
		longint unsigned ua;
		longint unsigned ub;
		logic [63:0] result;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		ua = {32'd0, a};
		ub = {32'd0, b};
		result = '0;
		if (op == MULT)
			result = sa * sb;
		else if (op == MULTU)
			result = ua * ub;
		else if (b == 32'd0)
			result = {a, 32'hffff_ffff};
		else if (op == DIV && a == 32'h8000_0000 && b == 32'hffff_ffff)
			result = {32'd0, a};
		else if (op == DIV)
			result = {32'(sa % sb), 32'(sa / sb)};
		else
			result = {32'(ua % ub), 32'(ua / ub)};
		return result;
	endfunction

	task automatic runFileCases();
		int fd;
		int fields;
		int lane;
		int code;
		int lineNo;
		string text;
		logic [31:0] srcA;
		logic [31:0] srcB;
		logic [31:0] expHi;
		logic [31:0] expLo;
		fd = $fopen("bench/mduInput.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the stimulus file bench/mduInput.txt");
			stopRun();
		end
		lineNo = 0;
		while ($fgets(text, fd) != 0)
		begin
			lineNo++;
			if (text.len() > 1 && text[0] != "#")
			begin
				fields = $sscanf(text, "%d %d %h %h %h %h", lane, code, srcA, srcB, expHi, expLo);
				if (fields != 6)
				begin
					$display("Stimulus line %0d could not be parsed", lineNo);
					stopRun();
				end
				if (lane < `MDU_LANES)
				begin
					startOp(lane, 3'(code), srcA, srcB);
					// Moves to HI or LO are readable right after the response
					if (code < 4)
						pollIdle(lane);
					checkLaneRegs(lane, expHi, expLo);
				end
			end
		end
		$fclose(fd);
	endtask

	initial
	begin
		logic [31:0] value;
		logic [31:0] bits;
		logic [63:0] expected;
		mduOpT batchOp [`MDU_LANES];
		logic [31:0] batchA [`MDU_LANES];
		logic [31:0] batchB [`MDU_LANES];
		int lane;
		int batch;
		int opsDone;
		reset = 1'b1;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		lfsrState = 32'h5deb_a8a1;
		failCount = 0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// Reset state
		for (lane = 0; lane < `MDU_LANES; lane++)
		begin
			readWord(laneAddr(lane, OffStatus), value, 0);
			checkValue($sformatf("lane %0d STATUS", lane), 32'd0, value);
			checkLaneRegs(lane, 32'd0, 32'd0);
		end

		runFileCases();

		// Lane 0 holds known values that unmapped space must not show or touch
		startOp(0, MTLO, 32'h1357_9bdf, 32'd0);
		startOp(0, MTHI, 32'h2468_ace0, 32'd0);
		if (`MDU_LANES < 8)
		begin
			startOp(`MDU_LANES, MTLO, 32'hdead_0001, 32'd0);
			readWord(laneAddr(`MDU_LANES, OffLo), value, 0);
			checkValue("unmapped lane LO", 32'd0, value);
		end
		checkLaneRegs(0, 32'h2468_ace0, 32'h1357_9bdf);
		readWord(laneAddr(0, 'h18), value, 0);
		checkValue("offset 0x18", 32'd0, value);
		readWord(laneAddr(0, 'h1C), value, 0);
		checkValue("offset 0x1C", 32'd0, value);

		// Second start lands while the divide is still running
		startOp(0, DIVU, 32'd1000, 32'd7);
		writeWord(laneAddr(0, OffCtrl), {29'd0, MULTU}, 0);
		pollIdle(0);
		expected = modelResult(DIVU, 32'd1000, 32'd7);
		checkLaneRegs(0, expected[63:32], expected[31:0]);

		// Back-pressure on both response channels
		writeWord(laneAddr(1, OffSrcA), 32'h5a5a_0f0f, 4);
		writeWord(laneAddr(1, OffCtrl), {29'd0, MTLO}, 6);
		writeWord(laneAddr(1, OffSrcA), 32'h0f0f_a5a5, 0);
		writeWord(laneAddr(1, OffCtrl), {29'd0, MTHI}, 0);
		readWord(laneAddr(1, OffLo), value, 6);
		checkValue("lane 1 LO after hold", 32'h5a5a_0f0f, value);
		readWord(laneAddr(1, OffHi), value, 0);
		checkValue("lane 1 HI after hold", 32'h0f0f_a5a5, value);

		// Random batches, one operation per lane in flight
		opsDone = 0;
		while (opsDone < RandomOps)
		begin
			batch = 0;
			while (batch < `MDU_LANES && opsDone + batch < RandomOps)
			begin
				randomBits(2, bits);
				batchOp[batch] = mduOpT'(bits[2:0]);
				randomBits(32, batchA[batch]);
				randomBits(32, batchB[batch]);
				randomBits(3, bits);
				// Small divisors now and then, zero included
				if (bits[2:0] == 3'd0)
					batchB[batch] = {28'd0, batchB[batch][3:0]};
				writeWord(laneAddr(batch, OffSrcA), batchA[batch], 0);
				writeWord(laneAddr(batch, OffSrcB), batchB[batch], 0);
				batch++;
			end
			// Starts go out back to back so that divides overlap across lanes
			for (lane = 0; lane < batch; lane++)
				writeWord(laneAddr(lane, OffCtrl), {29'd0, batchOp[lane]}, 0);
			for (lane = 0; lane < batch; lane++)
			begin
				pollIdle(lane);
				expected = modelResult(batchOp[lane], batchA[lane], batchB[lane]);
				checkLaneRegs(lane, expected[63:32], expected[31:0]);
			end
			opsDone += batch;
		end

		if (failCount == 0)
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
		else
			stopRun();
	end

endmodule

// File: mduCluster.f
+incdir+design
design/mduPkg.sv
design/mduCmdIf.sv
design/mduRegWrite.sv
design/mduLane.sv
design/mduRegRead.sv
design/mduCluster.sv
bench/mduClusterTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= mduClusterTb
FILELIST ?= mduCluster.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
PASS_TEXT = ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

// File: bench/mduInput.txt
# lane op srcA srcB expectedHi expectedLo
# lane and op are decimal, operands and results are hex
0 0 00000003 00000004 00000000 0000000c
0 0 fffffffd 00000004 ffffffff fffffff4
0 0 fffffffb fffffff9 00000000 00000023
0 1 ffffffff ffffffff fffffffe 00000001
0 0 80000000 80000000 40000000 00000000
0 1 80000000 00000002 00000001 00000000
0 0 12345678 00000010 00000001 23456780
1 2 00000064 00000007 00000002 0000000e
1 2 ffffff9c 00000007 fffffffe fffffff2
1 2 00000064 fffffff9 00000002 fffffff2
1 2 ffffff9c fffffff9 fffffffe 0000000e
1 3 ffffff9c 00000007 00000002 24924916
1 2 00001234 00000000 00001234 ffffffff
1 3 ffffff00 00000000 ffffff00 ffffffff
1 2 80000000 ffffffff 00000000 80000000
1 3 80000000 ffffffff 80000000 00000000
1 2 80000000 00000002 00000000 c0000000
# MTLO and MTHI touch only the named register
2 0 00000006 00000007 00000000 0000002a
2 4 cafef00d 00000000 00000000 cafef00d
2 5 0badbeef 00000000 0badbeef cafef00d
2 4 00000001 00000000 0badbeef 00000001
3 1 0000ffff 0000ffff 00000000 fffe0001
3 5 76543210 00000000 76543210 fffe0001
3 3 0000000a 00000003 00000001 00000003
# Code 6 is not an operation and leaves HI and LO alone
3 6 11111111 22222222 00000001 00000003
